/* dv/output_activation_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module output_activation_checker (
	input wire logic clk,
	input wire logic reset,
	input wire logic i_ready,
	input wire logic i_out_ready,
	input wire logic i_out_valid,
	input wire logic [activation_pkg::LANES-1:0][activation_pkg::DATA_W-1:0] i_out_value
);

	int failure_count = 0; // the testbench adds this to its own error counts

	ready_follows: assert property (@(posedge clk) i_out_ready == i_ready)
		else begin
			$error("o_ready does not follow i_ready");
			failure_count++;
		end

	valid_needs_ready: assert property (@(posedge clk) i_out_valid |-> i_ready)
		else begin
			$error("o_valid is high while i_ready is low");
			failure_count++;
		end

	valid_low_after_reset: assert property (@(posedge clk) reset |=> !i_out_valid)
		else begin
			$error("o_valid is high in the cycle after reset");
			failure_count++;
		end

	// a stalled edge must leave every lane output untouched
	output_held_in_stall: assert property (@(posedge clk) disable iff (reset)
		!i_ready |=> $stable(i_out_value))
		else begin
			$error("o_output_value changed after a stalled edge");
			failure_count++;
		end

endmodule

bind output_activation output_activation_checker checker_i (
	.clk(clk),
	.reset(reset),
	.i_ready(i_ready),
	.i_out_ready(o_ready),
	.i_out_valid(o_valid),
	.i_out_value(o_output_value)
);

`default_nettype wire

/* dv/output_activation_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module output_activation_tb;

	typedef logic [activation_pkg::DATA_W-1:0] sample_t;
	typedef logic [activation_pkg::LANES-1:0][activation_pkg::DATA_W-1:0] vector_t;

	localparam int SEED = 99477;
	localparam int CLK_PERIOD = 100;
	localparam int DIRECTED_VECTORS = 4;
	localparam int RANDOM_VECTORS = 300;
	localparam int STALL_VECTORS = 300;
	localparam int TOTAL_VECTORS = DIRECTED_VECTORS + RANDOM_VECTORS
		+ activation_pkg::SEG_COUNT + STALL_VECTORS;
	localparam int WATCHDOG_CYCLES = (TOTAL_VECTORS + activation_pkg::LATENCY + 20) * 4;
	localparam int PROD_FRAC = activation_pkg::FRAC_W + activation_pkg::COEF_FRAC_W;
	localparam int SEG_SPAN = 1 << (activation_pkg::FRAC_W - 2); // 0.25 in sample units

	logic clk = 1'b0;
	logic reset;
	logic i_valid;
	logic i_ready;
	vector_t i_stage1_result;
	vector_t i_bias;
	vector_t o_output_value;
	logic o_valid;
	logic o_ready;

	vector_t expected_q[$];
	int accept_edge_q[$];
	int enabled_edges;
	int value_errors;
	int protocol_errors;

	output_activation dut_i (
		.clk(clk),
		.reset(reset),
		.i_valid(i_valid),
		.i_ready(i_ready),
		.i_stage1_result(i_stage1_result),
		.i_bias(i_bias),
		.o_output_value(o_output_value),
		.o_valid(o_valid),
		.o_ready(o_ready)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	// sigmoid of the wrapped sum, reflected for negatives and rounded half up
	function automatic sample_t sigmoid_model(input sample_t a, input sample_t b);
		sample_t sum;
		longint value;
		longint magnitude;
		longint acc;
		int seg;
		sum = a + b;
		value = longint'($signed(sum));
		magnitude = (value < 0) ? -value : value;
		if (magnitude >= (longint'(8) << activation_pkg::FRAC_W)) begin
			acc = longint'(1) << PROD_FRAC;
		end else begin
			seg = int'(magnitude / SEG_SPAN);
			acc = magnitude * longint'(activation_pkg::SLOPE_TABLE[seg])
				+ (longint'(activation_pkg::INTERCEPT_TABLE[seg]) << activation_pkg::FRAC_W);
		end
		if (value < 0) begin
			acc = (longint'(1) << PROD_FRAC) - acc;
		end
		return sample_t'((acc + (longint'(1) << (activation_pkg::COEF_FRAC_W - 1)))
			>>> activation_pkg::COEF_FRAC_W);
	endfunction

	function automatic vector_t model_vector(input vector_t a, input vector_t b);
		vector_t result;
		for (int lane = 0; lane < activation_pkg::LANES; lane++) begin
			result[lane] = sigmoid_model(a[lane], b[lane]);
		end
		return result;
	endfunction

	// mostly near zero so the table is exercised, now and then any 18-bit word
	function automatic vector_t random_vector(input int span);
		vector_t v;
		for (int lane = 0; lane < activation_pkg::LANES; lane++) begin
			if ($urandom_range(0, 7) == 0) begin
				v[lane] = sample_t'($urandom());
			end else begin
				v[lane] = sample_t'($urandom_range(0, 2 * span - 1)) - sample_t'(span);
			end
		end
		return v;
	endfunction

	function automatic logic pick_ready(input int low_pct);
		return $urandom_range(0, 99) >= low_pct;
	endfunction

	task automatic check_anchor(input sample_t sum, input sample_t expected);
		sample_t got;
		got = sigmoid_model(sum, '0);
		assert (got == expected) else begin
			value_errors++;
			$display("FAILED at %0t: model output for sum %h expected %h, got %h",
				$time, sum, expected, got);
		end
	endtask

	task automatic check_outputs();
		vector_t expected;
		int accept_edge;
		assert (o_ready === i_ready) else begin
			protocol_errors++;
			$display("FAILED at %0t: o_ready expected %b, got %b", $time, i_ready, o_ready);
		end
		if (o_valid) begin
			if (expected_q.size() == 0) begin
				protocol_errors++;
				$display("ERROR at %0t: an output arrived with no vector in flight", $time);
			end else begin
				expected = expected_q.pop_front();
				accept_edge = accept_edge_q.pop_front();
				assert (enabled_edges - accept_edge == activation_pkg::LATENCY) else begin
					protocol_errors++;
					$display("ERROR at %0t: output came %0d enabled edges after its input",
						$time, enabled_edges - accept_edge);
				end
				for (int lane = 0; lane < activation_pkg::LANES; lane++) begin
					assert (o_output_value[lane] === expected[lane]) else begin
						value_errors++;
						$display("FAILED at %0t: o_output_value[%0d] expected %h, got %h",
							$time, lane, expected[lane], o_output_value[lane]);
					end
				end
			end
		end
	endtask

	// drive on the falling edge, look at outputs well before the next rising edge
	task automatic run_cycle(input logic valid, input logic ready, input vector_t a,
		input vector_t b);
		@(negedge clk);
		i_valid = valid;
		i_ready = ready;
		i_stage1_result = a;
		i_bias = b;
		#10;
		check_outputs();
		if (valid && ready) begin
			expected_q.push_back(model_vector(a, b));
			accept_edge_q.push_back(enabled_edges);
		end
		if (ready) begin
			enabled_edges++;
		end
	endtask

	task automatic send_vector(input vector_t a, input vector_t b, input int ready_low_pct);
		int gap;
		logic ready;
		logic accepted;
		gap = ($urandom_range(0, 3) == 0) ? int'($urandom_range(1, 3)) : 0;
		repeat (gap) begin
			run_cycle(1'b0, pick_ready(ready_low_pct), random_vector(4096), random_vector(4096));
		end
		accepted = 1'b0;
		while (!accepted) begin
			ready = pick_ready(ready_low_pct);
			run_cycle(1'b1, ready, a, b);
			accepted = ready;
		end
	endtask

	initial begin
		#(longint'(WATCHDOG_CYCLES) * CLK_PERIOD);
		$display("ERROR: watchdog expired before the tests finished");
		$display("test failed");
		$finish;
	end

	initial begin
		vector_t sums;
		vector_t bias;
		value_errors = 0;
		protocol_errors = 0;
		enabled_edges = 0;
		void'($urandom(SEED));
		reset = 1'b1;
		i_valid = 1'b0;
		i_ready = 1'b1;
		i_stage1_result = '0;
		i_bias = '0;

		check_anchor(18'h00000, 18'd512);
		check_anchor(18'h02000, 18'd1024);
		check_anchor(18'h3E000, 18'd0);
		check_anchor(18'h20000, 18'd0);

		repeat (4) begin
			@(negedge clk);
			assert (o_valid === 1'b0) else begin
				protocol_errors++;
				$display("FAILED at %0t: o_valid expected 0, got %b", $time, o_valid);
			end
		end
		reset = 1'b0;

		// zero, saturation on both sides, and sums that wrap
		send_vector({18'h04E20, 18'h1FFFF, 18'h02000, 18'h00000}, '0, 0);
		send_vector({18'h3DFFF, 18'h3B1E0, 18'h20000, 18'h3E000}, '0, 0);
		send_vector({18'h20100, 18'h20000, 18'h1F000, 18'h1FFFF},
			{18'h3FF00, 18'h3FFFF, 18'h01000, 18'h00001}, 0);
		send_vector('0, {18'h3FE00, 18'h00200, 18'h3E000, 18'h02000}, 0);

		repeat (RANDOM_VECTORS) begin
			send_vector(random_vector(16384), random_vector(4096), 0);
		end

		for (int k = 0; k < activation_pkg::SEG_COUNT; k++) begin
			sums = {sample_t'(1 - k * SEG_SPAN), sample_t'(-(k * SEG_SPAN)),
				sample_t'(k * SEG_SPAN - 1), sample_t'(k * SEG_SPAN)};
			bias = random_vector(1024);
			for (int lane = 0; lane < activation_pkg::LANES; lane++) begin
				sums[lane] = sums[lane] - bias[lane]; // stage-1 value that lands on the sum
			end
			send_vector(sums, bias, 0);
		end

		repeat (STALL_VECTORS) begin
			send_vector(random_vector(16384), random_vector(4096), 30);
		end

		repeat (activation_pkg::LATENCY + 2) begin
			run_cycle(1'b0, 1'b1, '0, '0);
		end
		if (expected_q.size() != 0) begin
			protocol_errors++;
			$display("ERROR: %0d accepted vectors never came out", expected_q.size());
		end

		$display("value errors: %0d, protocol errors: %0d, checker failures: %0d",
			value_errors, protocol_errors, dut_i.checker_i.failure_count);
		if (value_errors + protocol_errors + dut_i.checker_i.failure_count == 0) begin
			$display("test passed");
		end else begin
			$display("test failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* output_activation.f */
verilog/activation_pkg.sv
verilog/fixed_point_rounder.sv
verilog/pwl_segment_mac.sv
verilog/sigmoid_lane.sv
verilog/elementwise_adder.sv
verilog/output_activation.sv
dv/output_activation_checker.sv
dv/output_activation_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# compile and run the output_activation testbench with Verilator
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --timescale 1ns/1ps \
	--top-module output_activation_tb -f output_activation.f -o output_activation_sim &&
./obj_dir/output_activation_sim +verilator+error+limit+100 | tee /dev/stderr |
	grep -qx "test passed" &&
echo "PASS: simulation reported success" ||
{ echo "FAIL: build error or simulation did not pass"; exit 1; }

/* verilog/activation_pkg.sv */
`default_nettype none

package activation_pkg;

	localparam int DATA_W = 18;
	localparam int FRAC_W = 10;
	localparam int LANES = 4;
	localparam int LATENCY = 7; // adder 2, abs 1, mac 2, rounder 2

	localparam int COEF_W = 13;
	localparam int COEF_FRAC_W = 11;
	localparam int SEG_COUNT = 32;
	localparam int SEG_W = $clog2(SEG_COUNT);
	localparam int SEG_SHIFT = 8; // each segment covers 0.25
	localparam int SAT_W = DATA_W - SEG_W - SEG_SHIFT;

	localparam int ACC_W = 32;
	localparam int ACC_FRAC_W = 21; // magnitude frac bits plus slope frac bits
	localparam int ROUND_SHIFT = ACC_FRAC_W - FRAC_W;
	localparam logic [ACC_W-1:0] ONE_ACC = ACC_W'(1) << ACC_FRAC_W;

	// slope of each segment, 11 fraction bits
	localparam logic [COEF_W-1:0] SLOPE_TABLE [SEG_COUNT] = '{
		13'b0000111111101, 13'b0000111101110, 13'b0000111010001, 13'b0000110101001,
		13'b0000101111011, 13'b0000101001010, 13'b0000100011010, 13'b0000011101100,
		13'b0000011000011, 13'b0000010100000, 13'b0000010000001, 13'b0000001101000,
		13'b0000001010011, 13'b0000001000010, 13'b0000000110100, 13'b0000000101001,
		13'b0000000100000, 13'b0000000011001, 13'b0000000010100, 13'b0000000001111,
		13'b0000000001100, 13'b0000000001001, 13'b0000000000111, 13'b0000000000110,
		13'b0000000000100, 13'b0000000000011, 13'b0000000000011, 13'b0000000000010,
		13'b0000000000010, 13'b0000000000001, 13'b0000000000001, 13'b0000000000001
	};

	// intercept of each segment, 11 fraction bits
	localparam logic [COEF_W-1:0] INTERCEPT_TABLE [SEG_COUNT] = '{
		13'b0010000000000, 13'b0010000000100, 13'b0010000010010, 13'b0010000110000,
		13'b0010001011110, 13'b0010010011011, 13'b0010011100100, 13'b0010100110011,
		13'b0010110000101, 13'b0010111010101, 13'b0011000100010, 13'b0011001101000,
		13'b0011010100111, 13'b0011011011110, 13'b0011100001110, 13'b0011100111000,
		13'b0011101011011, 13'b0011101111000, 13'b0011110010001, 13'b0011110100101,
		13'b0011110110110, 13'b0011111000100, 13'b0011111001111, 13'b0011111011001,
		13'b0011111100000, 13'b0011111100110, 13'b0011111101011, 13'b0011111101111,
		13'b0011111110011, 13'b0011111110101, 13'b0011111110111, 13'b0011111111001
	};

	// same magnitude word seen as a number or as table lookup fields
	typedef union packed {
		logic [DATA_W-1:0] value;
		struct packed {
			logic [SAT_W-1:0] sat; // any bit set means magnitude of 8.0 or more
			logic [SEG_W-1:0] seg;
			logic [SEG_SHIFT-1:0] offset;
		} field;
	} magnitude_t;

endpackage

`default_nettype wire

/* verilog/elementwise_adder.sv */
`timescale 1ns/1ps
`default_nettype none

module elementwise_adder (
	input wire logic clk,
	input wire logic reset,
	input wire logic i_enable,
	input wire logic [activation_pkg::LANES-1:0][activation_pkg::DATA_W-1:0] i_operand_a,
	input wire logic [activation_pkg::LANES-1:0][activation_pkg::DATA_W-1:0] i_operand_b,
	output logic [activation_pkg::LANES-1:0][activation_pkg::DATA_W-1:0] o_sum
);

	logic [activation_pkg::LANES-1:0][activation_pkg::DATA_W-1:0] operand_a_q;
	logic [activation_pkg::LANES-1:0][activation_pkg::DATA_W-1:0] operand_b_q;

	always_ff @(posedge clk) begin
		if (reset) begin
			operand_a_q <= '0;
			operand_b_q <= '0;
			o_sum <= '0;
		end else if (i_enable) begin
			operand_a_q <= i_operand_a;
			operand_b_q <= i_operand_b;
			for (int lane = 0; lane < activation_pkg::LANES; lane++) begin
				o_sum[lane] <= operand_a_q[lane] + operand_b_q[lane]; // wraps to DATA_W
			end
		end
	end

endmodule

`default_nettype wire

/* verilog/fixed_point_rounder.sv */
`timescale 1ns/1ps
`default_nettype none

module fixed_point_rounder (
	input wire logic clk,
	input wire logic reset,
	input wire logic i_enable,
	input wire logic [activation_pkg::ACC_W-1:0] i_value,
	output logic [activation_pkg::ACC_W-1:0] o_value
);

	logic [activation_pkg::ACC_W-1:0] floor_value;
	logic [activation_pkg::ACC_W-1:0] floor_q;
	logic [activation_pkg::ACC_W-1:0] ceil_q;
	logic half_q;

	// arithmetic shift keeps a slightly negative reflection below zero
	assign floor_value = activation_pkg::ACC_W'($signed(i_value) >>> activation_pkg::ROUND_SHIFT);

	always_ff @(posedge clk) begin
		if (reset) begin
			floor_q <= '0;
			ceil_q <= '0;
			half_q <= 1'b0;
			o_value <= '0;
		end else if (i_enable) begin
			floor_q <= floor_value;
			ceil_q <= floor_value + 1'b1;
			half_q <= i_value[activation_pkg::ROUND_SHIFT-1]; // set when the dropped part is half or more
			o_value <= half_q ? ceil_q : floor_q;
		end
	end

endmodule

`default_nettype wire

/* verilog/output_activation.sv */
`timescale 1ns/1ps
`default_nettype none

module output_activation (
	input wire logic clk,
	input wire logic reset,
	input wire logic i_valid,
	input wire logic i_ready,
	input wire logic [activation_pkg::LANES-1:0][activation_pkg::DATA_W-1:0] i_stage1_result,
	input wire logic [activation_pkg::LANES-1:0][activation_pkg::DATA_W-1:0] i_bias,
	output logic [activation_pkg::LANES-1:0][activation_pkg::DATA_W-1:0] o_output_value,
	output logic o_valid,
	output logic o_ready
);

	logic [activation_pkg::LANES-1:0][activation_pkg::DATA_W-1:0] lane_sum;
	logic [activation_pkg::LATENCY-1:0] valid_pipe;

	elementwise_adder adder_i (
		.clk(clk),
		.reset(reset),
		.i_enable(i_ready),
		.i_operand_a(i_stage1_result),
		.i_operand_b(i_bias),
		.o_sum(lane_sum)
	);

	for (genvar lane = 0; lane < activation_pkg::LANES; lane++) begin : g_lane
		sigmoid_lane sigmoid_i (
			.clk(clk),
			.reset(reset),
			.i_enable(i_ready),
			.i_x(lane_sum[lane]),
			.o_y(o_output_value[lane])
		);
	end

	// one valid chain serves all lanes since they move in lockstep
	always_ff @(posedge clk) begin
		if (reset) begin
			valid_pipe <= '0;
		end else if (i_ready) begin
			valid_pipe <= {valid_pipe[activation_pkg::LATENCY-2:0], i_valid};
		end
	end

	assign o_valid = valid_pipe[activation_pkg::LATENCY-1] & i_ready;
	assign o_ready = i_ready;

endmodule

`default_nettype wire

/* verilog/pwl_segment_mac.sv */
`timescale 1ns/1ps
`default_nettype none

module pwl_segment_mac (
	input wire logic clk,
	input wire logic reset,
	input wire logic i_enable,
	input wire activation_pkg::magnitude_t i_magnitude,
	output logic [activation_pkg::ACC_W-1:0] o_acc
);

	logic [activation_pkg::COEF_W-1:0] slope;
	logic [activation_pkg::ACC_W-1:0] addend;
	logic [activation_pkg::DATA_W-1:0] magnitude_q;
	logic [activation_pkg::COEF_W-1:0] slope_q;
	logic [activation_pkg::ACC_W-1:0] addend_q;

	always_comb begin
		if (|i_magnitude.field.sat) begin
			slope = '0; // flat at 1.0 past the table
			addend = activation_pkg::ONE_ACC;
		end else begin
			slope = activation_pkg::SLOPE_TABLE[i_magnitude.field.seg];
			// intercept moved up to the product's fraction point
			addend = activation_pkg::ACC_W'(activation_pkg::INTERCEPT_TABLE[i_magnitude.field.seg])
				<< (activation_pkg::ACC_FRAC_W - activation_pkg::COEF_FRAC_W);
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			magnitude_q <= '0;
			slope_q <= '0;
			addend_q <= '0;
			o_acc <= '0;
		end else if (i_enable) begin
			magnitude_q <= i_magnitude.value;
			slope_q <= slope;
			addend_q <= addend;
			o_acc <= activation_pkg::ACC_W'(magnitude_q) * activation_pkg::ACC_W'(slope_q)
				+ addend_q;
		end
	end

endmodule

`default_nettype wire

/* verilog/sigmoid_lane.sv */
`timescale 1ns/1ps
`default_nettype none

module sigmoid_lane (
	input wire logic clk,
	input wire logic reset,
	input wire logic i_enable,
	input wire logic [activation_pkg::DATA_W-1:0] i_x,
	output logic [activation_pkg::DATA_W-1:0] o_y
);

	logic [activation_pkg::DATA_W-1:0] x_abs;
	activation_pkg::magnitude_t magnitude_q;
	logic [2:0] sign_pipe;
	logic [activation_pkg::ACC_W-1:0] mac_acc;
	logic [activation_pkg::ACC_W-1:0] reflected;
	logic [activation_pkg::ACC_W-1:0] rounded;

	// the most negative input stays negative here and lands in saturation
	always_comb begin
		if (i_x[activation_pkg::DATA_W-1]) begin
			x_abs = -i_x;
		end else begin
			x_abs = i_x;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			magnitude_q <= '0;
			sign_pipe <= '0;
		end else if (i_enable) begin
			magnitude_q.value <= x_abs;
			sign_pipe <= {sign_pipe[1:0], i_x[activation_pkg::DATA_W-1]}; // lines up with mac_acc
		end
	end

	pwl_segment_mac mac_i (
		.clk(clk),
		.reset(reset),
		.i_enable(i_enable),
		.i_magnitude(magnitude_q),
		.o_acc(mac_acc)
	);

	// sigmoid(-x) = 1 - sigmoid(x)
	always_comb begin
		if (sign_pipe[2]) begin
			reflected = activation_pkg::ONE_ACC - mac_acc;
		end else begin
			reflected = mac_acc;
		end
	end

	fixed_point_rounder rounder_i (
		.clk(clk),
		.reset(reset),
		.i_enable(i_enable),
		.i_value(reflected),
		.o_value(rounded)
	);

	assign o_y = rounded[activation_pkg::DATA_W-1:0];

endmodule

`default_nettype wire
